// ==== build.f ====
+incdir+verilog
+incdir+verification
verilog/scope_pkg.sv
verilog/channel_merger.sv
verilog/trigger_hub.sv
verilog/capture_gate.sv
verilog/scope_core.sv
verification/scope_core_tb.sv

// ==== verification/scope_core_tests.svh ====
`ifndef SCOPE_CORE_TESTS_SVH
`define SCOPE_CORE_TESTS_SVH

// Channel tag on top, fourteen zero bits, then the sample
function automatic logic [31:0] expected_word(input logic [1:0] chan, input logic [15:0] sample);
    return {chan, 14'h0000, sample};
endfunction

// Every frame_len-th word of a frame carries the last flag
task automatic compare_stream(input int count, input int frame_len);
    check_value("output word count", out_words.size(), count);
    for (int k = 0; k < count; k++) begin
        check_value($sformatf("out_word[%0d]", k), out_words[k], sent_words[k]);
        check_value($sformatf("out_last[%0d]", k), out_lasts[k], ((k + 1) % frame_len) == 0);
    end
endtask

task automatic reset_state();
    apply_reset(16'd1, 3'd0, 16'd0);
    repeat (3) begin
        @(negedge clock);
        check_value("out_valid", out_valid, 1'b0);
        check_value("capture_held", capture_held, 1'b0);
    end
endtask

task automatic merge_order();
    apply_reset(16'd4, 3'd0, 16'd0);
    drive_cycle(4'b1111);
    wait_for_words(4, 10);
    // Separate strobes leave in the order they arrived
    drive_cycle(4'b0100);
    drive_cycle(4'b0001);
    drive_cycle(4'b1000);
    drive_cycle(4'b0010);
    wait_for_words(8, 10);
    repeat (6) @(negedge clock);
    compare_stream(8, 4);
endtask

task automatic frame_marking();
    apply_reset(16'd3, 3'd0, 16'd0);
    for (int k = 0; k < 9; k++) begin
        drive_cycle(4'(1 << (k % 4)));
        @(negedge clock);
    end
    wait_for_words(9, 10);
    repeat (6) @(negedge clock);
    compare_stream(9, 3);
endtask

task automatic trigger_stop();
    int before_trigger;
    apply_reset(16'd4, 3'd3, 16'd5);
    before_trigger = 0;
    for (int k = 0; k < 24; k++) begin
        if (k == 6) begin
            trigger_in[3] = 1'b1;
        end
        // Two edges after the trigger goes high, all words before detection are out
        if (k == 8) begin
            before_trigger = out_words.size();
        end
        drive_cycle(4'(1 << (k % 4)));
    end
    repeat (6) @(negedge clock);
    check_value("words before trigger", before_trigger, 6);
    check_value("words after trigger", out_words.size() - before_trigger, 5);
    compare_stream(11, 4);
    check_value("capture_held", capture_held, 1'b1);
endtask

task automatic resume_after_ack();
    check_value("capture_held", capture_held, 1'b1);
    frame_length = 16'd2;
    @(negedge clock);
    capture_ack = 1'b1;
    @(negedge clock);
    capture_ack = 1'b0;
    check_value("capture_held", capture_held, 1'b0);
    sent_words.delete();
    out_words.delete();
    out_lasts.delete();
    for (int k = 0; k < 8; k++) begin
        case (k)
            1: trigger_in[0] = 1'b1;
            3: trigger_in[5] = 1'b1;
            5: trigger_in[0] = 1'b0;
            6: trigger_in[0] = 1'b1;
            default: ;
        endcase
        drive_cycle(4'(1 << (k % 4)));
    end
    wait_for_words(8, 12);
    repeat (6) @(negedge clock);
    compare_stream(8, 2);
    check_value("capture_held", capture_held, 1'b0);
endtask

`endif

// ==== verification/scope_core_tb.sv ====
`default_nettype none
`include "scope_settings.svh"

module scope_core_tb;

    localparam int CLOCK_PERIOD = 40;
    // Cycle budgets of the five tests in the order they run
    localparam int TOTAL_CYCLES = 10 + 40 + 50 + 50 + 40;
    localparam int WATCHDOG_MARGIN = 4000;

    logic clock;
    logic rst_n;
    logic [`SCOPE_N_CHANNELS-1:0] sample_strobe;
    scope_pkg::sample_t sample_data [`SCOPE_N_CHANNELS];
    logic [`SCOPE_N_TRIGGERS-1:0] trigger_in;
    logic [$clog2(`SCOPE_N_TRIGGERS)-1:0] trigger_select;
    logic [`SCOPE_COUNT_WIDTH-1:0] trigger_position;
    logic [`SCOPE_COUNT_WIDTH-1:0] frame_length;
    logic capture_ack;
    logic out_valid;
    scope_pkg::tagged_word_t out_word;
    logic out_last;
    logic capture_held;

    // Words driven into the channels, and words seen on the output
    logic [31:0] sent_words [$];
    logic [31:0] out_words [$];
    logic out_lasts [$];

    logic [31:0] lcg_state;

    scope_core i_scope_core (
        .clock(clock),
        .rst_n(rst_n),
        .sample_strobe(sample_strobe),
        .sample_data(sample_data),
        .trigger_in(trigger_in),
        .trigger_select(trigger_select),
        .trigger_position(trigger_position),
        .frame_length(frame_length),
        .capture_ack(capture_ack),
        .out_valid(out_valid),
        .out_word(out_word),
        .out_last(out_last),
        .capture_held(capture_held)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // Registered outputs still hold the previous cycle's values here
    always @(posedge clock) begin
        if (out_valid) begin
            out_words.push_back(out_word);
            out_lasts.push_back(out_last);
        end
    end

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic end_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic apply_reset(input logic [`SCOPE_COUNT_WIDTH-1:0] frame_len,
                               input logic [2:0] trig_sel,
                               input logic [`SCOPE_COUNT_WIDTH-1:0] trig_pos);
        @(negedge clock);
        rst_n = 1'b0;
        sample_strobe = '0;
        trigger_in = '0;
        capture_ack = 1'b0;
        frame_length = frame_len;
        trigger_select = trig_sel;
        trigger_position = trig_pos;
        repeat (4) begin
            @(negedge clock);
            check_value("out_valid", out_valid, 1'b0);
            check_value("out_last", out_last, 1'b0);
            check_value("capture_held", capture_held, 1'b0);
        end
        rst_n = 1'b1;
        @(negedge clock);
        check_value("out_valid", out_valid, 1'b0);
        check_value("out_last", out_last, 1'b0);
        check_value("capture_held", capture_held, 1'b0);
        sent_words.delete();
        out_words.delete();
        out_lasts.delete();
    endtask

    // Starts on a falling edge and returns on the next one with the strobes cleared
    task automatic drive_cycle(input logic [`SCOPE_N_CHANNELS-1:0] mask);
        logic [15:0] value;
        for (int ch = 0; ch < `SCOPE_N_CHANNELS; ch++) begin
            if (mask[ch]) begin
                value = next_random();
                sample_data[ch] = value;
                sent_words.push_back(expected_word(ch[1:0], value));
            end
        end
        sample_strobe = mask;
        @(negedge clock);
        sample_strobe = '0;
    endtask

    task automatic wait_for_words(input int count, input int budget);
        int cycles;
        cycles = 0;
        while (out_words.size() < count) begin
            if (cycles == budget) begin
                $display("Timed out waiting for %0d output words", count);
                end_with_failure();
            end else begin
                @(negedge clock);
                cycles++;
            end
        end
    endtask

`include "scope_core_tests.svh"

    initial begin
        #(TOTAL_CYCLES * CLOCK_PERIOD + WATCHDOG_MARGIN);
        $display("Watchdog expired before the tests finished");
        end_with_failure();
    end

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        sample_strobe = '0;
        for (int ch = 0; ch < `SCOPE_N_CHANNELS; ch++) begin
            sample_data[ch] = '0;
        end
        trigger_in = '0;
        trigger_select = '0;
        trigger_position = '0;
        frame_length = 16'd1;
        capture_ack = 1'b0;
        lcg_state = 32'd67387;
        reset_state();
        merge_order();
        frame_marking();
        trigger_stop();
        resume_after_ack();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/capture_gate.sv ====
`default_nettype none
`include "scope_settings.svh"

module capture_gate (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic merged_valid,
    input wire scope_pkg::tagged_word_t merged_word,
    input wire logic capture_inhibit,
    input wire logic [`SCOPE_COUNT_WIDTH-1:0] frame_length,
    output logic out_valid,
    output scope_pkg::tagged_word_t out_word,
    output logic out_last
);

    logic accept;
    logic frame_end;

    // Position of the next accepted word inside the current frame
    logic [`SCOPE_COUNT_WIDTH-1:0] frame_count;
    logic [`SCOPE_COUNT_WIDTH-1:0] frame_count_inc;

    assign accept = merged_valid && !capture_inhibit;
    assign frame_count_inc = frame_count + 1'b1;
    assign frame_end = (frame_count_inc == frame_length);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            frame_count <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else begin
            out_valid <= accept;
            out_last <= accept && frame_end;
            // Holding restarts framing so capture resumes on a frame boundary
            if (capture_inhibit) begin
                frame_count <= '0;
            end else if (accept) begin
                if (frame_end) begin
                    frame_count <= '0;
                end else begin
                    frame_count <= frame_count_inc;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_word <= merged_word;
        end
    end

    // A zero frame length would never produce a last word
    frame_length_nonzero: assert property (
        @(posedge clock) disable iff (!rst_n)
        frame_length != '0
    );

endmodule

`default_nettype wire

// ==== verilog/channel_merger.sv ====
`default_nettype none
`include "scope_settings.svh"

module channel_merger (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic [`SCOPE_N_CHANNELS-1:0] sample_strobe,
    input wire scope_pkg::sample_t sample_data [`SCOPE_N_CHANNELS],
    output logic merged_valid,
    output scope_pkg::tagged_word_t merged_word
);

    // One hold slot per channel
    logic [`SCOPE_N_CHANNELS-1:0] pending;
    scope_pkg::sample_t sample_reg [`SCOPE_N_CHANNELS];

    // Grant to the lowest indexed pending slot
    logic [`SCOPE_N_CHANNELS-1:0] grant;
    scope_pkg::chan_id_t sel;
    logic found;

    always_comb begin
        grant = '0;
        sel = '0;
        found = 1'b0;
        for (int i = 0; i < `SCOPE_N_CHANNELS; i++) begin
            if (pending[i] && !found) begin
                grant[i] = 1'b1;
                sel = scope_pkg::chan_id_t'(i);
                found = 1'b1;
            end
        end
    end

    // A new strobe wins over the clear of a slot leaving in the same cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~grant) | sample_strobe;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `SCOPE_N_CHANNELS; i++) begin
            if (sample_strobe[i]) begin
                sample_reg[i] <= sample_data[i];
            end
        end
    end

    assign merged_valid = found;

    assign merged_word = '{
        chan: sel,
        pad: '0,
        sample: sample_reg[sel]
    };

    // A strobe must never overwrite a sample that has not been issued yet
    no_slot_overrun: assert property (
        @(posedge clock) disable iff (!rst_n)
        (sample_strobe & pending & ~grant) == '0
    );

endmodule

`default_nettype wire

// ==== verilog/scope_core.sv ====
`default_nettype none
`include "scope_settings.svh"

module scope_core (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic [`SCOPE_N_CHANNELS-1:0] sample_strobe,
    input wire scope_pkg::sample_t sample_data [`SCOPE_N_CHANNELS],
    input wire logic [`SCOPE_N_TRIGGERS-1:0] trigger_in,
    input wire logic [$clog2(`SCOPE_N_TRIGGERS)-1:0] trigger_select,
    input wire logic [`SCOPE_COUNT_WIDTH-1:0] trigger_position,
    input wire logic [`SCOPE_COUNT_WIDTH-1:0] frame_length,
    input wire logic capture_ack,
    output logic out_valid,
    output scope_pkg::tagged_word_t out_word,
    output logic out_last,
    output logic capture_held
);

    // Serialized stream shared by the hub and the gate
    logic merged_valid;
    scope_pkg::tagged_word_t merged_word;

    logic capture_inhibit;

    channel_merger i_channel_merger (
        .clock(clock),
        .rst_n(rst_n),
        .sample_strobe(sample_strobe),
        .sample_data(sample_data),
        .merged_valid(merged_valid),
        .merged_word(merged_word)
    );

    // The hub counts words from the same stream that the gate forwards
    trigger_hub i_trigger_hub (
        .clock(clock),
        .rst_n(rst_n),
        .trigger_in(trigger_in),
        .trigger_select(trigger_select),
        .trigger_position(trigger_position),
        .capture_ack(capture_ack),
        .merged_valid(merged_valid),
        .capture_inhibit(capture_inhibit),
        .capture_held(capture_held)
    );

    capture_gate i_capture_gate (
        .clock(clock),
        .rst_n(rst_n),
        .merged_valid(merged_valid),
        .merged_word(merged_word),
        .capture_inhibit(capture_inhibit),
        .frame_length(frame_length),
        .out_valid(out_valid),
        .out_word(out_word),
        .out_last(out_last)
    );

endmodule

`default_nettype wire

// ==== verilog/scope_pkg.sv ====
`default_nettype none
`include "scope_settings.svh"

package scope_pkg;

    localparam int TAG_WIDTH = $clog2(`SCOPE_N_CHANNELS);
    localparam int WORD_WIDTH = 32;
    localparam int PAD_WIDTH = WORD_WIDTH - TAG_WIDTH - `SCOPE_SAMPLE_WIDTH;

    // One signed sample as delivered by a channel
    typedef logic signed [`SCOPE_SAMPLE_WIDTH-1:0] sample_t;

    typedef logic [TAG_WIDTH-1:0] chan_id_t;

    // Channel tag in the top bits, then zero padding, then the sample
    typedef struct packed {
        chan_id_t chan;
        logic [PAD_WIDTH-1:0] pad;
        sample_t sample;
    } tagged_word_t;

endpackage

`default_nettype wire

// ==== verilog/scope_settings.svh ====
`ifndef SCOPE_SETTINGS_SVH
`define SCOPE_SETTINGS_SVH

// Number of sample channels feeding the merger
`define SCOPE_N_CHANNELS 4

// Bits per sample value
`define SCOPE_SAMPLE_WIDTH 16

// Number of trigger lines watched by the hub
`define SCOPE_N_TRIGGERS 8

// Width of the frame length and trigger position counters
`define SCOPE_COUNT_WIDTH 16

`endif

// ==== verilog/trigger_hub.sv ====
`default_nettype none
`include "scope_settings.svh"

module trigger_hub (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic [`SCOPE_N_TRIGGERS-1:0] trigger_in,
    input wire logic [$clog2(`SCOPE_N_TRIGGERS)-1:0] trigger_select,
    input wire logic [`SCOPE_COUNT_WIDTH-1:0] trigger_position,
    input wire logic capture_ack,
    input wire logic merged_valid,
    output logic capture_inhibit,
    output logic capture_held
);

    typedef enum logic [1:0] {
        ARMED,
        COUNTING,
        HOLDING
    } hub_state_t;

    hub_state_t state;

    logic selected_line;
    logic selected_prev;
    logic trigger_edge;

    logic [`SCOPE_COUNT_WIDTH-1:0] word_count;
    logic [`SCOPE_COUNT_WIDTH-1:0] word_count_next;
    logic position_reached;

    assign selected_line = trigger_in[trigger_select];
    assign trigger_edge = selected_line && !selected_prev;

    assign word_count_next = word_count + 1'b1;

    // A zero position stops capture right after detection
    assign position_reached = (trigger_position == '0) ||
                              (merged_valid && (word_count_next == trigger_position));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= ARMED;
            selected_prev <= 1'b0;
            word_count <= '0;
        end else begin
            // The edge detector keeps tracking so a line held high cannot retrigger
            selected_prev <= selected_line;
            case (state)
                ARMED: begin
                    if (trigger_edge) begin
                        state <= COUNTING;
                        word_count <= '0;
                    end
                end
                COUNTING: begin
                    if (merged_valid) begin
                        word_count <= word_count_next;
                    end
                    if (position_reached) begin
                        state <= HOLDING;
                    end
                end
                HOLDING: begin
                    if (capture_ack) begin
                        state <= ARMED;
                    end
                end
                default: begin
                    state <= ARMED;
                end
            endcase
        end
    end

    assign capture_inhibit = (state == HOLDING);
    assign capture_held = (state == HOLDING);

    // Software only acknowledges a capture that has actually stopped
    ack_only_while_holding: assert property (
        @(posedge clock) disable iff (!rst_n)
        capture_ack |-> (state == HOLDING)
    );

endmodule

`default_nettype wire
